//--- design/ym_timer_pkg.sv
/* FM timer control package
   Widths, register numbers, bus structs and the write-port state type */
package ym_timer_pkg;

    typedef logic [7:0] reg_addr_t;     // Register number from an address write
    typedef logic [7:0] reg_data_t;     // Host data byte and status byte
    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;

    // One register write as seen by the register file
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } reg_write_t;

    // Timer levels held in the register file
    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;               // Run bits
        logic     load_b;
        logic     irq_en_a;
        logic     irq_en_b;
    } timer_ctrl_t;

    // Single cycle flag reset pulses
    typedef struct packed {
        logic clr_a;
        logic clr_b;
    } flag_clr_t;

    typedef enum logic {
        BUS_IDLE,
        BUS_BUSY
    } bus_state_t;

    localparam reg_addr_t REG_TA_HI = 8'h24;
    localparam reg_addr_t REG_TA_LO = 8'h25;
    localparam reg_addr_t REG_TB    = 8'h26;
    localparam reg_addr_t REG_TCTL  = 8'h27;

    localparam int TB_SUBDIV = 16;      // Sample ticks per timer B count

endpackage

//--- design/ym_bus_fsm.sv
/* Write-port controller
   Latches the register number, issues one strobe per data write and runs busy */
`timescale 1ns/1ps

module ym_bus_fsm
    import ym_timer_pkg::*;
#(
    parameter int BUSY_CYCLES = 32
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic [1:0] addr,
    input  reg_data_t  din,
    output logic       reg_wr,
    output reg_write_t wr,
    output logic       busy
);

    localparam int CNT_W = $clog2(BUSY_CYCLES + 1);

    bus_state_t       state;
    reg_addr_t        reg_num;          // Latched register number
    logic [CNT_W-1:0] busy_cnt;
    logic             write;
    logic             addr_wr;
    logic             data_wr;

    // Level strobes, sampled once per clock
    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && (addr == 2'b00);
    assign data_wr = write && (addr == 2'b01);   // Second bank ignored

    assign busy = (state == BUS_BUSY);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= BUS_IDLE;
            busy_cnt <= '0;
            reg_wr   <= 1'b0;
        end else begin
            reg_wr <= 1'b0;
            case (state)
                BUS_IDLE: begin
                    if (data_wr) begin
                        reg_wr   <= 1'b1;
                        busy_cnt <= CNT_W'(BUSY_CYCLES - 1);
                        state    <= BUS_BUSY;
                    end
                end
                BUS_BUSY: begin
                    // Data writes in here are lost
                    if (busy_cnt == '0) begin
                        state <= BUS_IDLE;
                    end else begin
                        busy_cnt <= busy_cnt - CNT_W'(1);
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (addr_wr) begin
            reg_num <= din;             // Accepted even while busy
        end
        if (data_wr && state == BUS_IDLE) begin
            wr.addr <= reg_num;
            wr.data <= din;
        end
    end

    // Busy drops exactly BUSY_CYCLES clocks after the strobe that raised it
    a_no_wr_when_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(reg_wr, BUSY_CYCLES)
    );

endmodule

//--- design/ym_timer_regs.sv
/* Timer register file
   Decodes writes to 0x24..0x27 into timer controls and flag reset pulses */
`timescale 1ns/1ps

module ym_timer_regs
    import ym_timer_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        reg_wr,
    input  reg_write_t  wr,
    output timer_ctrl_t ctrl,
    output flag_clr_t   clr
);

    logic ctl_wr;

    assign ctl_wr = reg_wr && (wr.addr == REG_TCTL);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl <= '0;
        end else if (reg_wr) begin
            case (wr.addr)
                REG_TA_HI: ctrl.value_a[9:2] <= wr.data;
                REG_TA_LO: ctrl.value_a[1:0] <= wr.data[1:0];
                REG_TB:    ctrl.value_b      <= wr.data;
                REG_TCTL: begin
                    ctrl.load_a   <= wr.data[0];
                    ctrl.load_b   <= wr.data[1];
                    ctrl.irq_en_a <= wr.data[2];
                    ctrl.irq_en_b <= wr.data[3];
                end
                default: ;              // Other registers are not ours
            endcase
        end
    end

    // Bits 4 and 5 of 0x27 only fire once
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clr <= '0;
        end else begin
            clr.clr_a <= ctl_wr && wr.data[4];
            clr.clr_b <= ctl_wr && wr.data[5];
        end
    end

    // Busy spacing keeps two strobes from landing back to back
    a_clr_a_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        clr.clr_a |=> !clr.clr_a
    );

    a_clr_b_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        clr.clr_b |=> !clr.clr_b
    );

endmodule

//--- design/ym_tick_gen.sv
/* Sample tick generator
   Divides the clock into the sample tick and the slower timer B tick */
`timescale 1ns/1ps

module ym_tick_gen
    import ym_timer_pkg::*;
#(
    parameter int SAMPLE_DIV = 144
) (
    input  logic clk,
    input  logic arst_n,
    output logic tick_a,
    output logic tick_b
);

    localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       sub_cnt;          // Sample ticks within one timer B count
    logic             div_end;

    assign div_end = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            sub_cnt <= '0;
            tick_a  <= 1'b0;
            tick_b  <= 1'b0;
        end else begin
            tick_a <= div_end;
            tick_b <= div_end && (sub_cnt == 4'(TB_SUBDIV - 1));
            if (div_end) begin
                div_cnt <= '0;
                sub_cnt <= sub_cnt + 4'd1;  // Wraps at 16
            end else begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
        end
    end

endmodule

//--- design/ym_timer.sv
/* Reloadable up-counting timer
   Loads on a rising run bit, counts on tick and pulses ovf when it wraps */
`timescale 1ns/1ps

module ym_timer #(
    parameter int WIDTH = 10
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             tick,
    input  logic             run,
    input  logic [WIDTH-1:0] reload,
    output logic             ovf
);

    logic [WIDTH-1:0] cnt;
    logic             run_q;
    logic             start;

    assign start = run && !run_q;       // Run bit just set

    // Wrap from all ones, same cycle as the tick
    assign ovf = run && !start && tick && (&cnt);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
            cnt   <= '0;
        end else begin
            run_q <= run;
            if (start) begin
                cnt <= reload;
            end else if (run && tick) begin
                if (&cnt) begin
                    cnt <= reload;
                end else begin
                    cnt <= cnt + WIDTH'(1);
                end
            end
        end
    end

    // Overflow needs a timer that was already running
    a_ovf_running: assert property (
        @(posedge clk) disable iff (!arst_n)
        ovf |-> run && $past(run)
    );

endmodule

//--- design/ym_status.sv
/* Status and interrupt block
   Holds the timer flags, drives irq_n and builds the status byte */
`timescale 1ns/1ps

module ym_status
    import ym_timer_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        busy,
    input  timer_ctrl_t ctrl,
    input  flag_clr_t   clr,
    input  logic        ovf_a,
    input  logic        ovf_b,
    output reg_data_t   dout,
    output logic        irq_n
);

    logic flag_a;
    logic flag_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            // Clear beats set
            if (clr.clr_a)   flag_a <= 1'b0;
            else if (ovf_a)  flag_a <= 1'b1;

            if (clr.clr_b)   flag_b <= 1'b0;
            else if (ovf_b)  flag_b <= 1'b1;
        end
    end

    assign irq_n = !((flag_a && ctrl.irq_en_a) || (flag_b && ctrl.irq_en_b));

    assign dout = {busy, 5'b00000, flag_b, flag_a};

endmodule

//--- design/ym_timer_top.sv
/* FM chip control side
   CPU write port, busy flag, timers A and B, status byte and interrupt */
`timescale 1ns/1ps

module ym_timer_top
    import ym_timer_pkg::*;
#(
    parameter int SAMPLE_DIV  = 144,
    parameter int BUSY_CYCLES = 32
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic [1:0] addr,
    input  reg_data_t  din,
    output reg_data_t  dout,
    output logic       irq_n
);

    logic        reg_wr;
    reg_write_t  wr;
    logic        busy;
    timer_ctrl_t ctrl;
    flag_clr_t   clr;
    logic        tick_a;            // Sample rate
    logic        tick_b;            // Sample rate / 16
    logic        ovf_a;
    logic        ovf_b;

    ym_bus_fsm #(.BUSY_CYCLES(BUSY_CYCLES)) u_bus_fsm (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .addr   ( addr   ),
        .din    ( din    ),
        .reg_wr ( reg_wr ),
        .wr     ( wr     ),
        .busy   ( busy   )
    );

    ym_timer_regs u_timer_regs (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .reg_wr ( reg_wr ),
        .wr     ( wr     ),
        .ctrl   ( ctrl   ),
        .clr    ( clr    )
    );

    ym_tick_gen #(.SAMPLE_DIV(SAMPLE_DIV)) u_tick_gen (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .tick_a ( tick_a ),
        .tick_b ( tick_b )
    );

    ym_timer #(.WIDTH(10)) u_timer_a (
        .clk    ( clk          ),
        .arst_n ( arst_n       ),
        .tick   ( tick_a       ),
        .run    ( ctrl.load_a  ),
        .reload ( ctrl.value_a ),
        .ovf    ( ovf_a        )
    );

    ym_timer #(.WIDTH(8)) u_timer_b (
        .clk    ( clk          ),
        .arst_n ( arst_n       ),
        .tick   ( tick_b       ),
        .run    ( ctrl.load_b  ),
        .reload ( ctrl.value_b ),
        .ovf    ( ovf_b        )
    );

    ym_status u_status (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .busy   ( busy   ),
        .ctrl   ( ctrl   ),
        .clr    ( clr    ),
        .ovf_a  ( ovf_a  ),
        .ovf_b  ( ovf_b  ),
        .dout   ( dout   ),
        .irq_n  ( irq_n  )
    );

endmodule

//--- verif/tb_ym_timer.sv
/* Testbench for the FM timer control side
   Directed tests of the write port, busy flag, timers A and B and the interrupt */
`timescale 1ns/1ps

module tb_ym_timer
    import ym_timer_pkg::*;
();

    localparam int SAMPLE_DIV  = 8;
    localparam int BUSY_CYCLES = 32;
    localparam int B_DIV       = SAMPLE_DIV * TB_SUBDIV;   // Clocks per timer B count

    logic       clk;
    logic       arst_n;
    logic       cs_n;
    logic       wr_n;
    logic [1:0] addr;
    reg_data_t  din;
    reg_data_t  dout;
    logic       irq_n;

    int errors;
    int tests_run;
    int tests_failed;
    int test_start_errors;
    int val_a;                          // Timer A reload, 1000..1020
    int val_b;                          // Timer B reload, 250..254

    ym_timer_top #(
        .SAMPLE_DIV  ( SAMPLE_DIV  ),
        .BUSY_CYCLES ( BUSY_CYCLES )
    ) ym_timer_top_inst (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .addr   ( addr   ),
        .din    ( din    ),
        .dout   ( dout   ),
        .irq_n  ( irq_n  )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // One host cycle with both strobes low
    task automatic write_bus(input logic [1:0] a, input reg_data_t d);
        @(negedge clk);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = a;
        din  = d;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic wait_busy_low(input int limit, output int cycles);
        cycles = 0;
        while (dout[7] && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (dout[7]) begin
            $display("busy was still high after %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic write_reg(input reg_addr_t num, input reg_data_t val);
        int n;
        write_bus(2'b00, num);
        write_bus(2'b01, val);
        wait_busy_low(BUSY_CYCLES + 2, n);
    endtask

    task automatic wait_irq(input int limit, output int cycles);
        cycles = 0;
        while (irq_n && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (irq_n) begin
            $display("irq_n did not fall within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic wait_flag_a(input int limit);
        int n;
        n = 0;
        while (!dout[0] && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!dout[0]) begin
            $display("flag A was not set within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic check_status(input reg_data_t exp);
        if (dout !== exp) begin
            $display("mismatch dout: got 0x%02h, expected 0x%02h", dout, exp);
            errors++;
        end
    endtask

    task automatic check_irq(input logic exp);
        if (irq_n !== exp) begin
            $display("mismatch irq_n: got 0x%0h, expected 0x%0h", irq_n, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int exp, input int window);
        if (got < exp - window || got > exp + window) begin
            $display("mismatch latency: got 0x%0h, expected 0x%0h +/- 0x%0h",
                     got, exp, window);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
            tests_failed++;
        end
    endtask

    task automatic test_reset();
        begin_test();
        check_status(8'h00);
        check_irq(1'b1);
        end_test("reset");
    endtask

    task automatic test_busy();
        int n;
        begin_test();
        write_bus(2'b00, REG_TA_HI);
        write_bus(2'b01, reg_data_t'(val_a >> 2));
        check_status(8'h80);            // Busy right after the write
        // Second write while busy must be lost
        write_bus(2'b00, REG_TA_HI);
        write_bus(2'b01, ~reg_data_t'(val_a >> 2));
        wait_busy_low(BUSY_CYCLES + 2 - 4, n);  // Four cycles already spent
        check_status(8'h00);
        end_test("busy");
    endtask

    task automatic test_timer_a();
        int lat;
        int exp_lat;
        int n;
        begin_test();
        exp_lat = (1024 - val_a) * SAMPLE_DIV;
        write_reg(REG_TA_LO, reg_data_t'(val_a & 3));
        write_bus(2'b00, REG_TCTL);
        write_bus(2'b01, 8'h05);        // load_a and irq_en_a
        wait_irq(exp_lat + 4 * SAMPLE_DIV, lat);
        check_latency(lat, exp_lat, SAMPLE_DIV);
        wait_busy_low(BUSY_CYCLES + 2, n);
        check_status(8'h01);
        check_irq(1'b0);
        end_test("timer_a");
    endtask

    task automatic test_flag_clear();
        int n;
        begin_test();
        write_reg(REG_TCTL, 8'h10);     // Reset flag A, timer A stops
        check_status(8'h00);
        check_irq(1'b1);
        write_bus(2'b00, REG_TCTL);
        write_bus(2'b01, 8'h01);        // Run A with its interrupt masked
        wait_flag_a((1024 - val_a + 2) * SAMPLE_DIV);
        wait_busy_low(BUSY_CYCLES + 2, n);
        check_status(8'h01);
        check_irq(1'b1);
        end_test("flag_clear");
    endtask

    task automatic test_timer_b();
        int lat;
        int exp_lat;
        int n;
        begin_test();
        exp_lat = (256 - val_b) * B_DIV;
        write_reg(REG_TB, reg_data_t'(val_b));
        write_bus(2'b00, REG_TCTL);
        write_bus(2'b01, 8'h1a);        // Reset flag A, run B with its interrupt
        wait_irq(exp_lat + 4 * B_DIV, lat);
        check_latency(lat, exp_lat, B_DIV);
        wait_busy_low(BUSY_CYCLES + 2, n);
        check_status(8'h02);
        check_irq(1'b0);
        end_test("timer_b");
    endtask

    initial begin
        arst_n            = 1'b0;
        cs_n              = 1'b1;
        wr_n              = 1'b1;
        addr              = 2'b00;
        din               = 8'h00;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        void'($urandom(32'h203e2548));
        val_a = 1000 + int'($urandom_range(20, 0));
        val_b = 250 + int'($urandom_range(4, 0));
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_reset();
        test_busy();
        test_timer_a();
        test_flag_clear();
        test_timer_b();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/ym_timer_pkg.sv
design/ym_bus_fsm.sv
design/ym_timer_regs.sv
design/ym_tick_gen.sv
design/ym_timer.sv
design/ym_status.sv
design/ym_timer_top.sv
verif/tb_ym_timer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_ym_timer
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
